//--- hdl/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } lc3b_aluop;

    // Condition code after reset, and the PC step to the next instruction
    localparam lc3b_nzp  CC_RESET = 3'b010;
    localparam lc3b_word PC_STEP  = 16'h0002;

    // Low five bits of ADD/AND hold either imm5 or two pad bits and SR2
    typedef union packed {
        logic [4:0] imm5;
        struct packed {
            logic [1:0] pad;
            lc3b_reg    src2;
        } regs;
    } lc3b_operand;

    typedef union packed {
        struct packed {
            lc3b_opcode  opcode;
            lc3b_reg     dest;
            lc3b_reg     src1;
            logic        imm_flag;
            lc3b_operand operand;
        } rr;
        struct packed {
            lc3b_opcode opcode;
            lc3b_reg    reg_ds;
            lc3b_reg    base;
            logic [5:0] offset6;
        } mem;
        struct packed {
            lc3b_opcode opcode;
            lc3b_nzp    nzp;
            logic [8:0] offset9;
        } br;
    } lc3b_instr;

    typedef struct packed {
        lc3b_opcode opcode;
        logic       load_regfile;
        logic       load_cc;
        logic       alumux_sel;
        logic       regfilemux_sel;
        logic       storemux_sel;
        logic       brmux_sel;
        lc3b_aluop  aluop;
        logic       mem_read;
        logic       mem_write;
    } lc3b_control_word;

    typedef struct packed {
        logic             valid;
        lc3b_control_word ctrl;
        lc3b_word         pc;
        lc3b_reg          dest;
        lc3b_word         sr1_val;
        lc3b_word         sr2_val;
        lc3b_word         imm5;
        lc3b_word         offset6;
        // Already shifted left by one
        lc3b_word         offset9;
        lc3b_nzp          nzp;
    } decode_out_t;

    typedef struct packed {
        logic             valid;
        lc3b_control_word ctrl;
        lc3b_reg          dest;
        lc3b_word         alu_result;
        lc3b_word         mem_addr;
        lc3b_word         store_data;
        logic             branch_taken;
        lc3b_word         branch_target;
    } execute_out_t;

endpackage : lc3b_types

//--- hdl/control_rom.sv
module control_rom (
    input  lc3b_types::lc3b_opcode       opcode,
    input  logic                         imm_enable,
    input  logic                         is_nop,
    output lc3b_types::lc3b_control_word ctrl
);

    import lc3b_types::*;

    always_comb begin
        // By default nothing loads and memory stays idle
        ctrl.opcode = opcode;
        ctrl.load_regfile = 1'b0;
        ctrl.load_cc = 1'b0;
        ctrl.alumux_sel = 1'b0;
        ctrl.regfilemux_sel = 1'b0;
        ctrl.storemux_sel = 1'b0;
        ctrl.brmux_sel = 1'b0;
        ctrl.aluop = alu_add;
        ctrl.mem_read = 1'b0;
        ctrl.mem_write = 1'b0;

        case (opcode)
            op_add: begin
                ctrl.aluop = alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                if (imm_enable) begin
                    // DR <= SR1 + SEXT(imm5)
                    ctrl.alumux_sel = 1'b1;
                end
            end

            op_and: begin
                ctrl.aluop = alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                if (imm_enable) begin
                    ctrl.alumux_sel = 1'b1;
                end
            end

            op_not: begin
                ctrl.aluop = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end

            op_ldr: begin
                // Address comes from the separate adder so the ALU just passes the base
                ctrl.aluop = alu_pass;
                ctrl.mem_read = 1'b1;

                // DR <= M[base + offset]
                ctrl.regfilemux_sel = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end

            op_str: begin
                ctrl.aluop = alu_pass;

                // Second read port fetches SR instead of SR2
                ctrl.storemux_sel = 1'b1;
                ctrl.mem_write = 1'b1;
            end

            op_br: begin
                // BR with nzp = 000 never branches
                if (!is_nop) begin
                    ctrl.brmux_sel = 1'b1;
                end
            end

            default: begin
                // Anything outside the supported set does nothing
                ctrl = '0;
            end
        endcase
    end

endmodule : control_rom

//--- hdl/regfile.sv
module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we,
    input  lc3b_types::lc3b_reg  wdest,
    input  lc3b_types::lc3b_word wdata,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);

    import lc3b_types::*;

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wdest] <= wdata;
        end
    end

    // Reads see the old value during the write cycle
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule : regfile

//--- hdl/decode_stage.sv
module decode_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  lc3b_types::lc3b_instr       instr,
    input  lc3b_types::lc3b_word        instr_pc,
    output lc3b_types::lc3b_reg         src_a,
    output lc3b_types::lc3b_reg         src_b,
    input  lc3b_types::lc3b_word        reg_a,
    input  lc3b_types::lc3b_word        reg_b,
    output lc3b_types::decode_out_t     dec
);

    import lc3b_types::*;

    lc3b_control_word ctrl_word;
    logic             is_nop;

    assign is_nop = (instr.br.nzp == 3'b000);

    control_rom rom (
        .opcode     (instr.rr.opcode),
        .imm_enable (instr.rr.imm_flag),
        .is_nop     (is_nop),
        .ctrl       (ctrl_word)
    );

    // SR1 and BaseR share bits 8:6
    assign src_a = instr.rr.src1;

    // STR reads its source register through the second port
    assign src_b = ctrl_word.storemux_sel ? instr.mem.reg_ds : instr.rr.operand.regs.src2;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec <= '0;
        end else begin
            dec.valid <= instr_valid;
            dec.ctrl <= ctrl_word;
            dec.pc <= instr_pc;
            dec.dest <= instr.rr.dest;
            dec.sr1_val <= reg_a;
            dec.sr2_val <= reg_b;
            dec.imm5 <= {{11{instr.rr.operand.imm5[4]}}, instr.rr.operand.imm5};
            dec.offset6 <= {{10{instr.mem.offset6[5]}}, instr.mem.offset6};
            dec.offset9 <= {{6{instr.br.offset9[8]}}, instr.br.offset9, 1'b0};
            dec.nzp <= instr.br.nzp;
        end
    end

endmodule : decode_stage

//--- hdl/execute_stage.sv
module execute_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  lc3b_types::decode_out_t  dec,
    input  lc3b_types::lc3b_nzp      cc,
    output lc3b_types::execute_out_t ex
);

    import lc3b_types::*;

    lc3b_word alu_b;
    lc3b_word alu_out;
    lc3b_word addr;
    lc3b_word target;
    logic     take;

    always_comb begin
        alu_b = dec.ctrl.alumux_sel ? dec.imm5 : dec.sr2_val;

        unique case (dec.ctrl.aluop)
            alu_add:  alu_out = dec.sr1_val + alu_b;
            alu_and:  alu_out = dec.sr1_val & alu_b;
            alu_not:  alu_out = ~dec.sr1_val;
            alu_pass: alu_out = dec.sr1_val;
        endcase
    end

    // offset6 counts in words
    assign addr = dec.sr1_val + {dec.offset6[14:0], 1'b0};

    assign target = dec.pc + PC_STEP + dec.offset9;

    // cc was written by an instruction at least three slots older
    assign take = dec.valid && dec.ctrl.brmux_sel && ((dec.nzp & cc) != 3'b000);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex <= '0;
        end else begin
            ex.valid <= dec.valid;
            // A bubble carries an empty control word so nothing downstream fires
            ex.ctrl <= dec.valid ? dec.ctrl : '0;
            ex.dest <= dec.dest;
            ex.alu_result <= alu_out;
            ex.mem_addr <= addr;
            ex.store_data <= dec.sr2_val;
            ex.branch_taken <= take;
            ex.branch_target <= target;
        end
    end

endmodule : execute_stage

//--- hdl/writeback_stage.sv
module writeback_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  lc3b_types::execute_out_t ex,
    input  lc3b_types::lc3b_word     mem_rdata,
    output logic                     we,
    output lc3b_types::lc3b_reg      wdest,
    output lc3b_types::lc3b_word     wdata,
    output lc3b_types::lc3b_nzp      cc
);

    import lc3b_types::*;

    lc3b_nzp next_cc;

    // LDR takes the memory word, everything else the ALU
    assign wdata = ex.ctrl.regfilemux_sel ? mem_rdata : ex.alu_result;
    assign wdest = ex.dest;
    assign we = ex.valid && ex.ctrl.load_regfile;

    always_comb begin
        if (wdata[15]) begin
            next_cc = 3'b100;
        end else if (wdata == '0) begin
            next_cc = 3'b010;
        end else begin
            next_cc = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cc <= CC_RESET;
        end else if (ex.valid && ex.ctrl.load_cc) begin
            cc <= next_cc;
        end
    end

endmodule : writeback_stage

//--- hdl/lc3b_pipe.sv
module lc3b_pipe (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  lc3b_types::lc3b_instr instr,
    input  lc3b_types::lc3b_word  instr_pc,
    input  lc3b_types::lc3b_word  mem_rdata,
    output logic                  mem_read,
    output logic                  mem_write,
    output lc3b_types::lc3b_word  mem_addr,
    output lc3b_types::lc3b_word  mem_wdata,
    output logic                  branch_taken,
    output lc3b_types::lc3b_word  branch_target,
    output logic                  wb_valid,
    output lc3b_types::lc3b_reg   wb_dest,
    output lc3b_types::lc3b_word  wb_data
);

    import lc3b_types::*;

    decode_out_t  dec;
    execute_out_t ex;
    lc3b_reg      src_a;
    lc3b_reg      src_b;
    lc3b_word     reg_a;
    lc3b_word     reg_b;
    lc3b_nzp      cc;

    decode_stage u_decode (
        .clk, .rst, .instr_valid, .instr, .instr_pc,
        .src_a, .src_b, .reg_a, .reg_b, .dec
    );

    regfile u_regfile (
        .clk, .rst,
        .we (wb_valid), .wdest (wb_dest), .wdata (wb_data),
        .src_a, .src_b, .reg_a, .reg_b
    );

    execute_stage u_execute (.clk, .rst, .dec, .cc, .ex);

    writeback_stage u_writeback (
        .clk, .rst, .ex, .mem_rdata,
        .we (wb_valid), .wdest (wb_dest), .wdata (wb_data), .cc
    );

    // Control bits in ex are already cleared for bubbles
    assign mem_read = ex.ctrl.mem_read;
    assign mem_write = ex.ctrl.mem_write;
    assign mem_addr = ex.mem_addr;
    assign mem_wdata = ex.store_data;
    assign branch_taken = ex.branch_taken;
    assign branch_target = ex.branch_target;

endmodule : lc3b_pipe

//--- bench/lc3b_pipe_checker.sv
module lc3b_pipe_checker (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic wb_valid,
    input logic branch_taken
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    mem_exclusive: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write are high in the same cycle");
            failures++;
        end

    // Each reset edge leaves writeback empty
    wb_idle_in_reset: assert property (@(posedge clk) rst |=> !wb_valid)
        else begin
            $error("wb_valid is high during reset");
            failures++;
        end

    // First instruction cannot reach writeback one cycle after reset
    wb_idle_after_reset: assert property (@(posedge clk) $fell(rst) |=> !wb_valid)
        else begin
            $error("wb_valid is high in the cycle after reset");
            failures++;
        end

    branch_no_wb: assert property (@(posedge clk) disable iff (rst) !(branch_taken && wb_valid))
        else begin
            $error("branch_taken and wb_valid are high in the same cycle");
            failures++;
        end

endmodule : lc3b_pipe_checker

bind lc3b_pipe lc3b_pipe_checker chk (.clk, .rst, .mem_read, .mem_write, .wb_valid, .branch_taken);

//--- bench/lc3b_pipe_tb.sv
module lc3b_pipe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import lc3b_types::*;

    localparam int COLS = 13;
    localparam int MAX_ROWS = 64;
    localparam int RESET_CYCLES = 4;
    localparam int LATENCY = 2;
    localparam int MARGIN = 10;

    // One instruction slot as read from the vector file
    typedef struct packed {
        logic      valid;
        lc3b_instr instr;
        lc3b_word  pc;
        lc3b_word  rdata;
        logic      mem_read;
        logic      mem_write;
        lc3b_word  mem_addr;
        lc3b_word  mem_wdata;
        logic      branch_taken;
        lc3b_word  branch_target;
        logic      wb_valid;
        lc3b_reg   wb_dest;
        lc3b_word  wb_data;
    } vector_t;

    logic      clk;
    logic      rst;
    logic      instr_valid;
    lc3b_instr instr;
    lc3b_word  instr_pc;
    lc3b_word  mem_rdata;
    logic      mem_read;
    logic      mem_write;
    lc3b_word  mem_addr;
    lc3b_word  mem_wdata;
    logic      branch_taken;
    lc3b_word  branch_target;
    logic      wb_valid;
    lc3b_reg   wb_dest;
    lc3b_word  wb_data;

    logic [15:0] vec_mem [COLS*MAX_ROWS];
    vector_t     rows [MAX_ROWS];
    int          num_rows = 0;
    int          cycles = 0;
    int          cycle_limit = MARGIN;
    int          word_errors = 0;
    int          reg_errors = 0;
    int          bit_errors = 0;
    int          other_errors = 0;

    lc3b_pipe uut (
        .clk, .rst, .instr_valid, .instr, .instr_pc, .mem_rdata,
        .mem_read, .mem_write, .mem_addr, .mem_wdata,
        .branch_taken, .branch_target, .wb_valid, .wb_dest, .wb_data
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic vector_t unpack_row(input int r);
        int      b;
        vector_t v;
        b = r * COLS;
        v.valid = vec_mem[b][0];
        v.instr = vec_mem[b+1];
        v.pc = vec_mem[b+2];
        v.rdata = vec_mem[b+3];
        v.mem_read = vec_mem[b+4][0];
        v.mem_write = vec_mem[b+5][0];
        v.mem_addr = vec_mem[b+6];
        v.mem_wdata = vec_mem[b+7];
        v.branch_taken = vec_mem[b+8][0];
        v.branch_target = vec_mem[b+9];
        v.wb_valid = vec_mem[b+10][0];
        v.wb_dest = vec_mem[b+11][2:0];
        v.wb_data = vec_mem[b+12];
        return v;
    endfunction

    task automatic check_word(input string name, input lc3b_word exp, input lc3b_word act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            word_errors++;
        end
    endtask

    task automatic check_reg(input string name, input lc3b_reg exp, input lc3b_reg act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            reg_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            bit_errors++;
        end
    endtask

    // Address, data and target only mean something when their strobe is expected
    task automatic compare_row(input vector_t v);
        check_bit("mem_read", v.mem_read, mem_read);
        check_bit("mem_write", v.mem_write, mem_write);
        if (v.mem_read || v.mem_write) begin
            check_word("mem_addr", v.mem_addr, mem_addr);
        end
        if (v.mem_write) begin
            check_word("mem_wdata", v.mem_wdata, mem_wdata);
        end
        check_bit("branch_taken", v.branch_taken, branch_taken);
        if (v.branch_taken) begin
            check_word("branch_target", v.branch_target, branch_target);
        end
        check_bit("wb_valid", v.wb_valid, wb_valid);
        if (v.wb_valid) begin
            check_reg("wb_dest", v.wb_dest, wb_dest);
            check_word("wb_data", v.wb_data, wb_data);
        end
    endtask

    initial begin
        int total;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        instr_pc = '0;
        mem_rdata = '0;

        // Empty slots read back with a top nibble of F, never a valid flag
        for (int a = 0; a < COLS*MAX_ROWS; a++) begin
            vec_mem[a] = 16'hF000 | 16'(a);
        end
        $readmemh("bench/lc3b_pipe_vectors.txt", vec_mem);
        while (num_rows < MAX_ROWS && vec_mem[num_rows*COLS] <= 16'h0001) begin
            rows[num_rows] = unpack_row(num_rows);
            num_rows++;
        end
        cycle_limit = num_rows + RESET_CYCLES + LATENCY + MARGIN;
        if (num_rows == 0) begin
            $display("No vector rows could be read from bench/lc3b_pipe_vectors.txt");
            other_errors++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int s = 0; s < num_rows + LATENCY; s++) begin
            instr_valid <= (s < num_rows) ? rows[s].valid : 1'b0;
            instr <= (s < num_rows) ? rows[s].instr : '0;
            instr_pc <= (s < num_rows) ? rows[s].pc : '0;
            // Row s-2 enters execute at this edge, so its load data goes out now
            if (s >= LATENCY) begin
                mem_rdata <= rows[s-LATENCY].rdata;
            end
            @(negedge clk);
            if (s >= LATENCY) begin
                compare_row(rows[s-LATENCY]);
            end
            @(posedge clk);
        end

        total = word_errors + reg_errors + bit_errors + other_errors + uut.chk.failures;
        $display("Errors: word %0d, reg %0d, bit %0d, assertion %0d, other %0d over %0d rows",
                 word_errors, reg_errors, bit_errors, uut.chk.failures, other_errors, num_rows);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout, the run did not end within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

endmodule : lc3b_pipe_tb

//--- all.f
hdl/lc3b_types.sv
hdl/control_rom.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/lc3b_pipe.sv
bench/lc3b_pipe_checker.sv
bench/lc3b_pipe_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = lc3b_pipe_tb
FILELIST  = all.f
RUN_ARGS  = +verilator+error+limit+100
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx 'All tests passed!'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/lc3b_pipe_vectors.txt
// valid instr pc rdata | mem_read mem_write mem_addr mem_wdata | branch_taken branch_target
// | wb_valid wb_dest wb_data, all hex, expected fields that do not apply are 0
1 6204 3000 1234  1 0 0008 0000  0 0000  1 1 1234  // LDR R1, R0, #4
1 643F 3002 8005  1 0 FFFE 0000  0 0000  1 2 8005  // LDR R2, R0, #-1
1 661F 3004 00F0  1 0 003E 0000  0 0000  1 3 00F0  // LDR R3, R0, #31
0 6204 3006 DEAD  0 0 0000 0000  0 0000  0 0 0000  // bubble holding an LDR word
1 1842 3008 0000  0 0 0000 0000  0 0000  1 4 9239  // ADD R4, R1, R2
1 1AF0 300A 0000  0 0 0000 0000  0 0000  1 5 00E0  // ADD R5, R3, #-16
1 5C43 300C 0000  0 0 0000 0000  0 0000  1 6 0030  // AND R6, R1, R3
1 5EAF 300E 0000  0 0 0000 0000  0 0000  1 7 0005  // AND R7, R2, #15
1 933F 3010 0000  0 0 0000 0000  0 0000  1 1 6DC6  // NOT R1, R4, cc p
1 7402 3012 0000  0 1 0004 8005  0 0000  0 0 0000  // STR R2, R0, #2
1 01FF 3014 0000  0 0 0000 0000  0 0000  0 0 0000  // BR nzp clear
1 03FD 3016 0000  0 0 0000 0000  1 3012  0 0 0000  // BRp #-3
1 0805 3018 0000  0 0 0000 0000  0 0000  0 0 0000  // BRn #5
1 0220 301A 0000  0 0 0000 0000  1 305C  0 0 0000  // BRp #32
1 F025 301C 0000  0 0 0000 0000  0 0000  0 0 0000  // TRAP, unsupported
1 95FF 301E 0000  0 0 0000 0000  0 0000  1 2 FFFA  // NOT R2, R7, cc n
1 7A20 3020 0000  0 1 FFC0 00E0  0 0000  0 0 0000  // STR R5, R0, #-32
0 0000 3022 0000  0 0 0000 0000  0 0000  0 0 0000  // bubble
1 0900 3024 0000  0 0 0000 0000  1 2E26  0 0 0000  // BRn #-256
1 0401 3026 0000  0 0 0000 0000  0 0000  0 0 0000  // BRz #1
1 16A6 3028 0000  0 0 0000 0000  0 0000  1 3 0000  // ADD R3, R2, #6, cc z
1 7F81 302A 0000  0 1 0032 0005  0 0000  0 0 0000  // STR R7, R6, #1
1 0000 302C 0000  0 0 0000 0000  0 0000  0 0 0000  // BR nzp clear
1 0404 302E 0000  0 0 0000 0000  1 3038  0 0 0000  // BRz #4
1 68C1 3030 ABCD  1 0 0002 0000  0 0000  1 4 ABCD  // LDR R4, R3, #1
